//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= demux.f
TOP       ?= tb_demux_top
RTL_TOP   ?= demux_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ** PASS **

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary -j 0 $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	@out="$$($(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

//--- demux.f
demux_pkg.sv
demux_ingress.sv
demux_dispatch.sv
demux_egress.sv
demux_top.sv
tb_demux_top.sv

//--- demux_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

module demux_dispatch (
    input  logic                axis_aclk,
    input  logic                axis_resetn,

    input  logic                beat_valid,
    input  logic                beat_first,
    input  logic                beat_tlast,
    input  demux_pkg::user_id_t beat_id,
    output logic                beat_ready,

    output demux_pkg::lane_t    lane_valid,
    input  demux_pkg::lane_t    lane_ready
);
    import demux_pkg::*;

    dispatch_state_e state;
    lane_t           lane_sel;
    lane_t           id_lane;
    lane_t           cur_lane;
    logic            id_drop;
    logic            xfer;

    assign id_drop = (beat_id >= user_id_t'(NUM_PORTS));
    assign id_lane = id_drop ? '0 : (lane_t'(1) << beat_id);

    always_comb begin
        cur_lane   = '0;
        beat_ready = 1'b0;
        case (state)
            IDLE: begin
                if (beat_first) begin
                    cur_lane   = id_lane;
                    beat_ready = id_drop || (|(id_lane & lane_ready));
                end else begin
                    // stray beat outside a packet is sunk
                    beat_ready = 1'b1;
                end
            end
            FORWARD: begin
                cur_lane   = lane_sel;
                beat_ready = |(lane_sel & lane_ready);
            end
            DISCARD: begin
                beat_ready = 1'b1;
            end
            default: begin
                beat_ready = 1'b1;
            end
        endcase
    end

    assign lane_valid = beat_valid ? cur_lane : '0;
    assign xfer       = beat_valid && beat_ready;

    always_ff @(posedge axis_aclk) begin
        if (axis_resetn) begin
            state    <= IDLE;
            lane_sel <= '0;
        end else if (xfer) begin
            case (state)
                IDLE: begin
                    lane_sel <= id_lane;
                    // Single-beat packets never leave IDLE
                    if (beat_first && !beat_tlast) begin
                        state <= id_drop ? DISCARD : FORWARD;
                    end
                end
                default: begin
                    if (beat_tlast) begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    a_lane_onehot: assert property (
        @(posedge axis_aclk) disable iff (axis_resetn)
        $onehot0(lane_valid)
    );

    // Ingress must mark the beat after a last beat as a packet start
    a_idle_first: assert property (
        @(posedge axis_aclk) disable iff (axis_resetn)
        beat_valid && state == IDLE |-> beat_first
    );

endmodule

`default_nettype wire

//--- demux_egress.sv
`timescale 1ns/1ps
`default_nettype none

module demux_egress (
    input  logic              axis_aclk,
    input  logic              axis_resetn,

    input  demux_pkg::data_t  in_tdata,
    input  demux_pkg::keep_t  in_tkeep,
    input  demux_pkg::tuser_t in_tuser,
    input  logic              in_tlast,
    input  logic              in_valid,
    output logic              in_ready,

    output demux_pkg::data_t  m_tdata,
    output demux_pkg::keep_t  m_tkeep,
    output demux_pkg::tuser_t m_tuser,
    output logic              m_tlast,
    output logic              m_tvalid,
    input  logic              m_tready
);

    logic load;

    assign in_ready = !m_tvalid || m_tready;
    assign load     = in_valid && in_ready;

    always_ff @(posedge axis_aclk) begin
        if (axis_resetn) begin
            m_tvalid <= 1'b0;
        end else if (load) begin
            m_tvalid <= 1'b1;
        end else if (m_tready) begin
            m_tvalid <= 1'b0;
        end
    end

    always_ff @(posedge axis_aclk) begin
        if (load) begin
            m_tdata <= in_tdata;
            m_tkeep <= in_tkeep;
            m_tuser <= in_tuser;
            m_tlast <= in_tlast;
        end
    end

    a_m_hold: assert property (
        @(posedge axis_aclk) disable iff (axis_resetn)
        m_tvalid && !m_tready |=> m_tvalid && $stable({m_tdata, m_tkeep, m_tuser, m_tlast})
    );

endmodule

`default_nettype wire

//--- demux_ingress.sv
`timescale 1ns/1ps
`default_nettype none

module demux_ingress (
    input  logic                axis_aclk,
    input  logic                axis_resetn,

    input  demux_pkg::data_t    s_axis_tdata,
    input  demux_pkg::keep_t    s_axis_tkeep,
    input  demux_pkg::tuser_t   s_axis_tuser,
    input  logic                s_axis_tlast,
    input  logic                s_axis_tvalid,
    output logic                s_axis_tready,
    input  demux_pkg::user_id_t user_id,

    output demux_pkg::data_t    beat_tdata,
    output demux_pkg::keep_t    beat_tkeep,
    output demux_pkg::tuser_t   beat_tuser,
    output logic                beat_tlast,
    output demux_pkg::user_id_t beat_id,
    output logic                beat_first,
    output logic                beat_valid,
    input  logic                beat_ready
);
    import demux_pkg::*;

    logic     run;
    logic     in_pkt;
    logic     accept;
    user_id_t held_id;

    // Slave is held off until the first cycle out of reset
    assign s_axis_tready = run && (!beat_valid || beat_ready);
    assign accept        = s_axis_tvalid && s_axis_tready;

    always_ff @(posedge axis_aclk) begin
        if (axis_resetn) begin
            run        <= 1'b0;
            in_pkt     <= 1'b0;
            beat_valid <= 1'b0;
        end else begin
            run <= 1'b1;
            if (accept) begin
                beat_valid <= 1'b1;
                in_pkt     <= !s_axis_tlast;
            end else if (beat_valid && beat_ready) begin
                beat_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_aclk) begin
        if (accept) begin
            beat_tdata <= s_axis_tdata;
            beat_tkeep <= s_axis_tkeep;
            beat_tuser <= s_axis_tuser;
            beat_tlast <= s_axis_tlast;
            beat_first <= !in_pkt;
            // Id is only taken at a packet start
            if (!in_pkt) begin
                held_id <= user_id;
                beat_id <= user_id;
            end else begin
                beat_id <= held_id;
            end
        end
    end

    a_beat_hold: assert property (
        @(posedge axis_aclk) disable iff (axis_resetn)
        beat_valid && !beat_ready |=> beat_valid &&
            $stable({beat_tdata, beat_tkeep, beat_tuser, beat_tlast, beat_id, beat_first})
    );

endmodule

`default_nettype wire

//--- demux_pkg.sv
`default_nettype none

package demux_pkg;

    // Stream widths
    localparam int DATA_WIDTH    = 32;
    localparam int KEEP_WIDTH    = DATA_WIDTH / 8;
    localparam int TUSER_WIDTH   = 16;
    localparam int USER_ID_WIDTH = 8;

    // Ids at or above the port count are dropped
    localparam int NUM_PORTS     = 4;

    typedef logic [DATA_WIDTH-1:0]    data_t;
    typedef logic [KEEP_WIDTH-1:0]    keep_t;
    typedef logic [TUSER_WIDTH-1:0]   tuser_t;
    typedef logic [USER_ID_WIDTH-1:0] user_id_t;

    // One bit per master port
    typedef logic [NUM_PORTS-1:0]     lane_t;

    typedef enum logic [1:0] {
        IDLE,
        FORWARD,
        DISCARD
    } dispatch_state_e;

endpackage

`default_nettype wire

//--- demux_top.sv
`timescale 1ns/1ps
`default_nettype none

module demux_top (
    input  logic                axis_aclk,
    input  logic                axis_resetn,

    input  demux_pkg::data_t    s_axis_tdata,
    input  demux_pkg::keep_t    s_axis_tkeep,
    input  demux_pkg::tuser_t   s_axis_tuser,
    input  logic                s_axis_tlast,
    input  logic                s_axis_tvalid,
    output logic                s_axis_tready,
    input  demux_pkg::user_id_t user_id,

    output demux_pkg::data_t    m_axis_0_tdata,
    output demux_pkg::keep_t    m_axis_0_tkeep,
    output demux_pkg::tuser_t   m_axis_0_tuser,
    output logic                m_axis_0_tlast,
    output logic                m_axis_0_tvalid,
    input  logic                m_axis_0_tready,

    output demux_pkg::data_t    m_axis_1_tdata,
    output demux_pkg::keep_t    m_axis_1_tkeep,
    output demux_pkg::tuser_t   m_axis_1_tuser,
    output logic                m_axis_1_tlast,
    output logic                m_axis_1_tvalid,
    input  logic                m_axis_1_tready,

    output demux_pkg::data_t    m_axis_2_tdata,
    output demux_pkg::keep_t    m_axis_2_tkeep,
    output demux_pkg::tuser_t   m_axis_2_tuser,
    output logic                m_axis_2_tlast,
    output logic                m_axis_2_tvalid,
    input  logic                m_axis_2_tready,

    output demux_pkg::data_t    m_axis_3_tdata,
    output demux_pkg::keep_t    m_axis_3_tkeep,
    output demux_pkg::tuser_t   m_axis_3_tuser,
    output logic                m_axis_3_tlast,
    output logic                m_axis_3_tvalid,
    input  logic                m_axis_3_tready
);
    import demux_pkg::*;

    data_t    beat_tdata;
    keep_t    beat_tkeep;
    tuser_t   beat_tuser;
    logic     beat_tlast;
    user_id_t beat_id;
    logic     beat_first;
    logic     beat_valid;
    logic     beat_ready;

    lane_t    lane_valid;
    lane_t    lane_ready;

    // Per-port outputs indexed by lane
    data_t    port_tdata [NUM_PORTS];
    keep_t    port_tkeep [NUM_PORTS];
    tuser_t   port_tuser [NUM_PORTS];
    lane_t    port_tlast;
    lane_t    port_tvalid;
    lane_t    port_tready;

    demux_ingress u_ingress (
        .axis_aclk     (axis_aclk),
        .axis_resetn   (axis_resetn),
        .s_axis_tdata  (s_axis_tdata),
        .s_axis_tkeep  (s_axis_tkeep),
        .s_axis_tuser  (s_axis_tuser),
        .s_axis_tlast  (s_axis_tlast),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .user_id       (user_id),
        .beat_tdata    (beat_tdata),
        .beat_tkeep    (beat_tkeep),
        .beat_tuser    (beat_tuser),
        .beat_tlast    (beat_tlast),
        .beat_id       (beat_id),
        .beat_first    (beat_first),
        .beat_valid    (beat_valid),
        .beat_ready    (beat_ready)
    );

    demux_dispatch u_dispatch (
        .axis_aclk   (axis_aclk),
        .axis_resetn (axis_resetn),
        .beat_valid  (beat_valid),
        .beat_first  (beat_first),
        .beat_tlast  (beat_tlast),
        .beat_id     (beat_id),
        .beat_ready  (beat_ready),
        .lane_valid  (lane_valid),
        .lane_ready  (lane_ready)
    );

    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_port
        demux_egress u_egress (
            .axis_aclk   (axis_aclk),
            .axis_resetn (axis_resetn),
            .in_tdata    (beat_tdata),
            .in_tkeep    (beat_tkeep),
            .in_tuser    (beat_tuser),
            .in_tlast    (beat_tlast),
            .in_valid    (lane_valid[i]),
            .in_ready    (lane_ready[i]),
            .m_tdata     (port_tdata[i]),
            .m_tkeep     (port_tkeep[i]),
            .m_tuser     (port_tuser[i]),
            .m_tlast     (port_tlast[i]),
            .m_tvalid    (port_tvalid[i]),
            .m_tready    (port_tready[i])
        );
    end

    assign port_tready = {m_axis_3_tready, m_axis_2_tready, m_axis_1_tready, m_axis_0_tready};

    assign m_axis_0_tdata  = port_tdata[0];
    assign m_axis_0_tkeep  = port_tkeep[0];
    assign m_axis_0_tuser  = port_tuser[0];
    assign m_axis_0_tlast  = port_tlast[0];
    assign m_axis_0_tvalid = port_tvalid[0];

    assign m_axis_1_tdata  = port_tdata[1];
    assign m_axis_1_tkeep  = port_tkeep[1];
    assign m_axis_1_tuser  = port_tuser[1];
    assign m_axis_1_tlast  = port_tlast[1];
    assign m_axis_1_tvalid = port_tvalid[1];

    assign m_axis_2_tdata  = port_tdata[2];
    assign m_axis_2_tkeep  = port_tkeep[2];
    assign m_axis_2_tuser  = port_tuser[2];
    assign m_axis_2_tlast  = port_tlast[2];
    assign m_axis_2_tvalid = port_tvalid[2];

    assign m_axis_3_tdata  = port_tdata[3];
    assign m_axis_3_tkeep  = port_tkeep[3];
    assign m_axis_3_tuser  = port_tuser[3];
    assign m_axis_3_tlast  = port_tlast[3];
    assign m_axis_3_tvalid = port_tvalid[3];

endmodule

`default_nettype wire

//--- tb_demux_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_demux_top;
    import demux_pkg::*;

    localparam int CLK_HALF     = 50;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_PKTS     = 300;
    localparam int WAIT_LIMIT   = 1000;
    localparam int BEAT_W       = DATA_WIDTH + KEEP_WIDTH + TUSER_WIDTH + 1;

    logic     axis_aclk;
    logic     axis_resetn;

    data_t    s_axis_tdata;
    keep_t    s_axis_tkeep;
    tuser_t   s_axis_tuser;
    logic     s_axis_tlast;
    logic     s_axis_tvalid;
    logic     s_axis_tready;
    user_id_t user_id;

    data_t    m_tdata [NUM_PORTS];
    keep_t    m_tkeep [NUM_PORTS];
    tuser_t   m_tuser [NUM_PORTS];
    lane_t    m_tlast;
    lane_t    m_tvalid;
    lane_t    m_tready;

    integer   seed;
    logic     rand_ready;
    logic     timed_out;
    int       mismatches;
    int       latency_errs;
    int       unexpected;
    int       missing;
    int       timeouts;

    // Expected beats and acceptance times per port (-1 when latency is not checked)
    logic [BEAT_W-1:0] exp_q [NUM_PORTS][$];
    longint            exp_time [NUM_PORTS][$];

    demux_top u_demux_top (
        .axis_aclk       (axis_aclk),
        .axis_resetn     (axis_resetn),
        .s_axis_tdata    (s_axis_tdata),
        .s_axis_tkeep    (s_axis_tkeep),
        .s_axis_tuser    (s_axis_tuser),
        .s_axis_tlast    (s_axis_tlast),
        .s_axis_tvalid   (s_axis_tvalid),
        .s_axis_tready   (s_axis_tready),
        .user_id         (user_id),
        .m_axis_0_tdata  (m_tdata[0]),
        .m_axis_0_tkeep  (m_tkeep[0]),
        .m_axis_0_tuser  (m_tuser[0]),
        .m_axis_0_tlast  (m_tlast[0]),
        .m_axis_0_tvalid (m_tvalid[0]),
        .m_axis_0_tready (m_tready[0]),
        .m_axis_1_tdata  (m_tdata[1]),
        .m_axis_1_tkeep  (m_tkeep[1]),
        .m_axis_1_tuser  (m_tuser[1]),
        .m_axis_1_tlast  (m_tlast[1]),
        .m_axis_1_tvalid (m_tvalid[1]),
        .m_axis_1_tready (m_tready[1]),
        .m_axis_2_tdata  (m_tdata[2]),
        .m_axis_2_tkeep  (m_tkeep[2]),
        .m_axis_2_tuser  (m_tuser[2]),
        .m_axis_2_tlast  (m_tlast[2]),
        .m_axis_2_tvalid (m_tvalid[2]),
        .m_axis_2_tready (m_tready[2]),
        .m_axis_3_tdata  (m_tdata[3]),
        .m_axis_3_tkeep  (m_tkeep[3]),
        .m_axis_3_tuser  (m_tuser[3]),
        .m_axis_3_tlast  (m_tlast[3]),
        .m_axis_3_tvalid (m_tvalid[3]),
        .m_axis_3_tready (m_tready[3])
    );

    initial begin
        axis_aclk = 1'b0;
        forever #CLK_HALF axis_aclk = ~axis_aclk;
    end

    // Destination port of a first-beat id or -1 for a dropped packet
    function automatic int expected_port(input user_id_t id);
        if (id < user_id_t'(NUM_PORTS)) begin
            return int'(id);
        end
        return -1;
    endfunction

    function automatic int pending_beats();
        int n;
        n = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            n += exp_q[p].size();
        end
        return n;
    endfunction

    // Sample the slave handshake at a clock edge and then drive the port readies
    task automatic step(output logic accepted, output longint edge_t);
        @(posedge axis_aclk);
        accepted = s_axis_tvalid && s_axis_tready;
        edge_t   = longint'($time);
        #1;
        if (rand_ready) begin
            m_tready = lane_t'($random(seed) | $random(seed));
        end else begin
            m_tready = '1;
        end
    endtask

    task automatic check_idle_outputs();
        if (s_axis_tready !== 1'b0) begin
            $display("[FAIL] s_axis_tready got %h expected %h", s_axis_tready, 1'b0);
            mismatches++;
        end
        for (int p = 0; p < NUM_PORTS; p++) begin
            if (m_tvalid[p] !== 1'b0) begin
                $display("[FAIL] m_axis_%0d_tvalid got %h expected %h", p, m_tvalid[p], 1'b0);
                mismatches++;
            end
        end
    endtask

    task automatic send_beat(input user_id_t id, input logic first, input logic last,
                             input int port);
        logic   accepted;
        longint edge_t;
        int     waited;
        s_axis_tdata  = data_t'($random(seed));
        s_axis_tkeep  = keep_t'($random(seed));
        s_axis_tuser  = tuser_t'($random(seed));
        s_axis_tlast  = last;
        s_axis_tvalid = 1'b1;
        // Later beats get a noise id that must be ignored
        user_id  = first ? id : user_id_t'($random(seed));
        accepted = 1'b0;
        edge_t   = 0;
        waited   = 0;
        while (!accepted && waited < WAIT_LIMIT) begin
            step(accepted, edge_t);
            waited++;
        end
        if (!accepted) begin
            $display("[%0t] timeout: slave beat not accepted within %0d cycles",
                     $time, WAIT_LIMIT);
            timeouts++;
            timed_out = 1'b1;
        end else if (port >= 0) begin
            exp_q[port].push_back({s_axis_tdata, s_axis_tkeep, s_axis_tuser, s_axis_tlast});
            exp_time[port].push_back(rand_ready ? longint'(-1) : edge_t);
        end
    endtask

    task automatic send_packet();
        int       len;
        int       port;
        user_id_t id;
        logic     acc;
        longint   edge_t;
        len  = 1 + int'($unsigned($random(seed)) % 6);
        id   = user_id_t'($unsigned($random(seed)) % 6);
        port = expected_port(id);
        for (int b = 0; b < len; b++) begin
            if (timed_out) begin
                break;
            end
            send_beat(id, b == 0, b == len - 1, port);
            // Occasional gap between beats
            if (($random(seed) & 3) == 0) begin
                s_axis_tvalid = 1'b0;
                step(acc, edge_t);
            end
        end
        s_axis_tvalid = 1'b0;
    endtask

    task automatic drain();
        logic   acc;
        longint edge_t;
        int     waited;
        waited = 0;
        while (pending_beats() != 0 && waited < WAIT_LIMIT) begin
            step(acc, edge_t);
            waited++;
        end
        if (pending_beats() != 0) begin
            $display("[%0t] timeout: %0d expected beats never left the master ports",
                     $time, pending_beats());
            timeouts++;
            timed_out = 1'b1;
        end
    endtask

    task automatic compare_master_beat(input int p);
        data_t  e_data;
        keep_t  e_keep;
        tuser_t e_user;
        logic   e_last;
        longint acc_t;
        if (exp_q[p].size() == 0) begin
            $display("[%0t] port %0d sent a beat that no packet was routed to", $time, p);
            unexpected++;
        end else begin
            {e_data, e_keep, e_user, e_last} = exp_q[p].pop_front();
            acc_t = exp_time[p].pop_front();
            if (m_tdata[p] !== e_data) begin
                $display("[FAIL] m_axis_%0d_tdata got %08h expected %08h", p, m_tdata[p], e_data);
                mismatches++;
            end
            if (m_tkeep[p] !== e_keep) begin
                $display("[FAIL] m_axis_%0d_tkeep got %h expected %h", p, m_tkeep[p], e_keep);
                mismatches++;
            end
            if (m_tuser[p] !== e_user) begin
                $display("[FAIL] m_axis_%0d_tuser got %04h expected %04h", p, m_tuser[p], e_user);
                mismatches++;
            end
            if (m_tlast[p] !== e_last) begin
                $display("[FAIL] m_axis_%0d_tlast got %h expected %h", p, m_tlast[p], e_last);
                mismatches++;
            end
            if (acc_t >= 0 && longint'($time) - acc_t != longint'(4 * CLK_HALF)) begin
                $display("[%0t] port %0d beat took %0d ns from acceptance, not 2 cycles",
                         $time, p, longint'($time) - acc_t);
                latency_errs++;
            end
        end
    endtask

    always @(posedge axis_aclk) begin
        if (!axis_resetn) begin
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (m_tvalid[p] && m_tready[p]) begin
                    compare_master_beat(p);
                end
            end
        end
    end

    initial begin
        logic   acc;
        longint edge_t;
        seed          = 32'h0c4b_3585;
        rand_ready    = 1'b0;
        timed_out     = 1'b0;
        mismatches    = 0;
        latency_errs  = 0;
        unexpected    = 0;
        missing       = 0;
        timeouts      = 0;
        axis_resetn   = 1'b1;
        s_axis_tdata  = '0;
        s_axis_tkeep  = '0;
        s_axis_tuser  = '0;
        s_axis_tlast  = 1'b0;
        s_axis_tvalid = 1'b0;
        user_id       = '0;
        m_tready      = '1;

        repeat (RESET_CYCLES) @(posedge axis_aclk);
        check_idle_outputs();
        #1;
        axis_resetn = 1'b0;
        // Slave side stays held off for the first cycle out of reset
        @(posedge axis_aclk);
        check_idle_outputs();
        #1;

        for (int pkt = 0; pkt < NUM_PKTS; pkt++) begin
            if (timed_out) begin
                break;
            end
            // Second half runs with random back-pressure on every port
            if (pkt == NUM_PKTS / 2) begin
                drain();
                rand_ready = 1'b1;
            end
            send_packet();
        end
        if (!timed_out) begin
            drain();
        end
        repeat (8) step(acc, edge_t);
        missing = pending_beats();

        $display("errors: mismatch %0d, latency %0d, unexpected %0d, missing %0d, timeout %0d",
                 mismatches, latency_errs, unexpected, missing, timeouts);
        if (mismatches + latency_errs + unexpected + missing + timeouts == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire
